// File: Makefile
VERILATOR  := verilator
TOP        := dcache_tb
FILELIST   := tb.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_FLAGS  := +verilator+error+limit+1000
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!
SOURCES    := $(wildcard source/*.sv) $(wildcard test/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/dcache_data_store.sv
`timescale 1ns/1ps

module dcache_data_store (
    input  logic                                 clk,
    input  logic                                 rd_en,
    input  logic [dcache_pkg::index_w-1:0]       rd_index,
    input  logic                                 hit_way,
    input  logic [dcache_pkg::word_sel_w-1:0]    word_sel,
    input  logic                                 victim_way,
    input  logic                                 refill_we,
    input  logic [dcache_pkg::index_w-1:0]       refill_index,
    input  logic [dcache_pkg::line_w-1:0]        refill_line,
    input  logic                                 store_we,
    input  logic                                 store_way,
    input  logic [dcache_pkg::index_w-1:0]       store_index,
    input  logic [dcache_pkg::word_sel_w-1:0]    store_word,
    input  logic [dcache_pkg::word_w-1:0]        store_data,
    output logic [dcache_pkg::word_w-1:0]        hit_word,
    output logic [dcache_pkg::line_w-1:0]        victim_line
);
    logic [dcache_pkg::line_w-1:0] lines [dcache_pkg::num_ways][dcache_pkg::num_sets];
    logic [dcache_pkg::line_w-1:0] fwd_line [dcache_pkg::num_ways];
    logic [dcache_pkg::line_w-1:0] rd_line  [dcache_pkg::num_ways];

    always_comb begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            fwd_line[w] = lines[w][rd_index];
            if (refill_we && victim_way == w && refill_index == rd_index)
                fwd_line[w] = refill_line;
            if (store_we && store_way == w && store_index == rd_index)
                fwd_line[w][store_word*dcache_pkg::word_w +: dcache_pkg::word_w] = store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we)
            lines[victim_way][refill_index] <= refill_line;
        if (store_we)  // single word of the line
            lines[store_way][store_index][store_word*dcache_pkg::word_w +: dcache_pkg::word_w]
                <= store_data;
        if (rd_en) begin
            for (int w = 0; w < dcache_pkg::num_ways; w++)
                rd_line[w] <= fwd_line[w];
        end
    end

    assign hit_word    = rd_line[hit_way][word_sel*dcache_pkg::word_w +: dcache_pkg::word_w];
    assign victim_line = rd_line[victim_way];

endmodule

// File: source/dcache_miss_fsm.sv
`timescale 1ns/1ps

module dcache_miss_fsm (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             lookup_miss,
    input  logic [dcache_pkg::tag_w-1:0]     held_tag,
    input  logic [dcache_pkg::index_w-1:0]   held_index,
    input  logic                             victim_way,
    input  logic [dcache_pkg::tag_w-1:0]     victim_tag,
    input  logic                             victim_dirty,
    input  logic [dcache_pkg::line_w-1:0]    victim_line,
    input  logic                             mem_rd_rdy,
    input  logic                             mem_ret_valid,
    input  logic [dcache_pkg::line_w-1:0]    mem_ret_data,
    input  logic                             mem_wr_rdy,
    input  logic                             mem_wr_done,
    output logic                             mem_rd_req,
    output logic [dcache_pkg::addr_w-1:0]    mem_rd_addr,
    output logic                             mem_wr_req,
    output logic [dcache_pkg::addr_w-1:0]    mem_wr_addr,
    output logic [dcache_pkg::line_w-1:0]    mem_wr_data,
    output logic                             refill_we,
    output logic [dcache_pkg::index_w-1:0]   refill_index,
    output logic [dcache_pkg::line_w-1:0]    refill_line,
    output logic                             refill_done,
    output dcache_pkg::miss_state_t          miss_state
);
    dcache_pkg::miss_state_t      state;
    dcache_pkg::miss_state_t      state_nxt;
    logic [dcache_pkg::tag_w-1:0] vic_tag_q;

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::LOOKUP:
                if (lookup_miss)
                    state_nxt = victim_dirty ? dcache_pkg::MISS_DIRTY : dcache_pkg::MISS_CLEAN;
            dcache_pkg::MISS_DIRTY:
                if (mem_wr_rdy)
                    state_nxt = dcache_pkg::WRITEBACK;
            dcache_pkg::WRITEBACK:
                if (mem_wr_done)
                    state_nxt = dcache_pkg::MISS_CLEAN;
            dcache_pkg::MISS_CLEAN:
                if (mem_rd_rdy)
                    state_nxt = dcache_pkg::REFILL;
            dcache_pkg::REFILL:
                if (mem_ret_valid)
                    state_nxt = dcache_pkg::REFILL_DONE;
            default:
                state_nxt = dcache_pkg::LOOKUP;  // REFILL_DONE retries the lookup
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= dcache_pkg::LOOKUP;
        else
            state <= state_nxt;
    end

    // victim is frozen for the whole miss
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::LOOKUP && lookup_miss)
            vic_tag_q <= victim_tag;
    end

    assign mem_rd_req  = (state == dcache_pkg::MISS_CLEAN);
    assign mem_rd_addr = {held_tag, held_index, {dcache_pkg::offset_w{1'b0}}};
    assign mem_wr_req  = (state == dcache_pkg::MISS_DIRTY);
    assign mem_wr_addr = {vic_tag_q, held_index, {dcache_pkg::offset_w{1'b0}}};
    assign mem_wr_data = victim_line;

    assign refill_we    = (state == dcache_pkg::REFILL) && mem_ret_valid;
    assign refill_index = held_index;
    assign refill_line  = mem_ret_data;  // word 0 in the low bits
    assign refill_done  = (state == dcache_pkg::REFILL_DONE);
    assign miss_state   = state;

endmodule

// File: source/dcache_pkg.sv
package dcache_pkg;

    localparam int addr_w         = 32;
    localparam int word_w         = 32;
    localparam int strb_w         = 4;   // one strobe bit per byte
    localparam int words_per_line = 4;
    localparam int line_w         = 128;
    localparam int num_sets       = 16;
    localparam int num_ways       = 2;

    // address fields, low to high
    localparam int offset_w       = 4;
    localparam int index_w        = 4;
    localparam int tag_w          = 24;
    localparam int word_sel_w     = 2;

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,    // victim line waits for the write channel
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE    // re-read before the retried lookup
    } miss_state_t;

endpackage

// File: source/dcache_req_stage.sv
`timescale 1ns/1ps

module dcache_req_stage (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    req_valid,
    input  logic                                                    req_write,
    input  logic [dcache_pkg::addr_w-1:0]                           req_addr,
    input  logic [dcache_pkg::word_w-1:0]                           req_wdata,
    input  logic [dcache_pkg::strb_w-1:0]                           req_wstrb,
    input  logic [dcache_pkg::num_ways-1:0][dcache_pkg::tag_w-1:0] way_tag,
    input  logic [dcache_pkg::num_ways-1:0]                         way_valid,
    input  logic [dcache_pkg::word_w-1:0]                           hit_word,
    input  logic                                                    refill_done,
    input  dcache_pkg::miss_state_t                                 miss_state,
    output logic                                                    busy,
    output logic [dcache_pkg::word_w-1:0]                           rdata,
    output logic                                                    rd_en,
    output logic [dcache_pkg::index_w-1:0]                          rd_index,
    output logic [dcache_pkg::tag_w-1:0]                            held_tag,
    output logic [dcache_pkg::index_w-1:0]                          held_index,
    output logic                                                    lookup_miss,
    output logic                                                    hit_way,
    output logic [dcache_pkg::word_sel_w-1:0]                       word_sel,
    output logic                                                    store_we,
    output logic                                                    store_way,
    output logic [dcache_pkg::index_w-1:0]                          store_index,
    output logic [dcache_pkg::word_sel_w-1:0]                       store_word,
    output logic [dcache_pkg::word_w-1:0]                           store_data,
    output logic                                                    plru_we,
    output logic                                                    plru_way
);
    logic                            pend;
    logic                            held_write;
    logic [dcache_pkg::word_w-1:0]   held_wdata;
    logic [dcache_pkg::strb_w-1:0]   held_wstrb;
    logic [dcache_pkg::num_ways-1:0] hit;
    logic                            hit_any;
    logic                            lookup_ok;
    logic                            accept;
    logic                            store_hit;
    logic [dcache_pkg::word_w-1:0]   merged;

    always_comb begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            hit[w] = way_valid[w] && (way_tag[w] == held_tag);
        end
    end

    assign hit_any     = |hit;
    assign hit_way     = hit[1];
    assign lookup_ok   = (miss_state == dcache_pkg::LOOKUP);
    assign lookup_miss = pend && lookup_ok && !hit_any;
    assign store_hit   = pend && lookup_ok && hit_any && held_write;
    assign busy        = pend && (!lookup_ok || !hit_any || held_write);  // loads finish on hit
    assign accept      = req_valid && !busy;
    assign rdata       = hit_word;

    assign rd_en    = accept || refill_done;
    assign rd_index = refill_done ? held_index
                                  : req_addr[dcache_pkg::offset_w +: dcache_pkg::index_w];

    assign plru_we  = pend && lookup_ok && hit_any;
    assign plru_way = hit_way;

    always_comb begin
        for (int b = 0; b < dcache_pkg::strb_w; b++) begin
            merged[b*8 +: 8] = held_wstrb[b] ? held_wdata[b*8 +: 8] : hit_word[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend     <= 1'b0;
            store_we <= 1'b0;
        end else begin
            if (accept)
                pend <= 1'b1;
            else if (!busy || store_hit)
                pend <= 1'b0;
            store_we <= store_hit;  // array write one cycle after the hit
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_write <= req_write;
            held_tag   <= req_addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];
            held_index <= req_addr[dcache_pkg::offset_w +: dcache_pkg::index_w];
            word_sel   <= req_addr[dcache_pkg::offset_w-1 -: dcache_pkg::word_sel_w];
            held_wdata <= req_wdata;
            held_wstrb <= req_wstrb;
        end
        if (store_hit) begin
            store_way   <= hit_way;
            store_index <= held_index;
            store_word  <= word_sel;
            store_data  <= merged;
        end
    end

endmodule

// File: source/dcache_tag_store.sv
`timescale 1ns/1ps

module dcache_tag_store (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    rd_en,
    input  logic [dcache_pkg::index_w-1:0]                          rd_index,
    input  logic                                                    refill_we,
    input  logic [dcache_pkg::tag_w-1:0]                            refill_tag,
    input  logic [dcache_pkg::index_w-1:0]                          refill_index,
    input  logic                                                    store_we,
    input  logic                                                    store_way,
    input  logic [dcache_pkg::index_w-1:0]                          store_index,
    input  logic                                                    plru_we,
    input  logic                                                    plru_way,
    output logic [dcache_pkg::num_ways-1:0][dcache_pkg::tag_w-1:0] way_tag,
    output logic [dcache_pkg::num_ways-1:0]                         way_valid,
    output logic                                                    victim_way,
    output logic [dcache_pkg::tag_w-1:0]                            victim_tag,
    output logic                                                    victim_dirty
);
    logic [dcache_pkg::tag_w-1:0]    tags  [dcache_pkg::num_ways][dcache_pkg::num_sets];
    logic [dcache_pkg::num_sets-1:0] valid [dcache_pkg::num_ways];
    logic [dcache_pkg::num_sets-1:0] dirty [dcache_pkg::num_ways];
    logic [dcache_pkg::num_sets-1:0] plru;  // way to evict next

    logic [dcache_pkg::num_ways-1:0][dcache_pkg::tag_w-1:0] fwd_tag;
    logic [dcache_pkg::num_ways-1:0] fwd_valid;
    logic [dcache_pkg::num_ways-1:0] fwd_dirty;
    logic [dcache_pkg::num_ways-1:0] dirty_q;
    logic [dcache_pkg::index_w-1:0]  idx_q;

    // write-first on a same-cycle update of the read set
    always_comb begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            fwd_tag[w]   = tags[w][rd_index];
            fwd_valid[w] = valid[w][rd_index];
            fwd_dirty[w] = dirty[w][rd_index];
            if (refill_we && victim_way == w && refill_index == rd_index) begin
                fwd_tag[w]   = refill_tag;
                fwd_valid[w] = 1'b1;
                fwd_dirty[w] = 1'b0;
            end
            if (store_we && store_way == w && store_index == rd_index)
                fwd_dirty[w] = 1'b1;
        end
    end

    assign victim_way   = plru[idx_q];
    assign victim_tag   = way_tag[victim_way];
    assign victim_dirty = dirty_q[victim_way];

    always_ff @(posedge clk) begin
        if (refill_we)
            tags[victim_way][refill_index] <= refill_tag;
        if (rd_en)
            way_tag <= fwd_tag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < dcache_pkg::num_ways; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            plru      <= '0;
            way_valid <= '0;
            dirty_q   <= '0;
            idx_q     <= '0;
        end else begin
            if (refill_we) begin
                valid[victim_way][refill_index] <= 1'b1;
                dirty[victim_way][refill_index] <= 1'b0;
            end
            if (store_we)
                dirty[store_way][store_index] <= 1'b1;
            if (plru_we)
                plru[idx_q] <= ~plru_way;  // point away from the way just used
            if (rd_en) begin
                way_valid <= fwd_valid;
                dirty_q   <= fwd_dirty;
                idx_q     <= rd_index;
            end
        end
    end

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             req_valid,
    input  logic                             req_write,
    input  logic [dcache_pkg::addr_w-1:0]    req_addr,
    input  logic [dcache_pkg::word_w-1:0]    req_wdata,
    input  logic [dcache_pkg::strb_w-1:0]    req_wstrb,
    output logic                             busy,
    output logic [dcache_pkg::word_w-1:0]    rdata,
    output logic                             mem_rd_req,
    output logic [dcache_pkg::addr_w-1:0]    mem_rd_addr,
    input  logic                             mem_rd_rdy,
    input  logic                             mem_ret_valid,
    input  logic [dcache_pkg::line_w-1:0]    mem_ret_data,
    output logic                             mem_wr_req,
    output logic [dcache_pkg::addr_w-1:0]    mem_wr_addr,
    output logic [dcache_pkg::line_w-1:0]    mem_wr_data,
    input  logic                             mem_wr_rdy,
    input  logic                             mem_wr_done
);
    logic                                                    rd_en;
    logic [dcache_pkg::index_w-1:0]                          rd_index;
    logic [dcache_pkg::tag_w-1:0]                            held_tag;
    logic [dcache_pkg::index_w-1:0]                          held_index;
    logic                                                    lookup_miss;
    logic                                                    hit_way;
    logic [dcache_pkg::word_sel_w-1:0]                       word_sel;
    logic                                                    store_we;
    logic                                                    store_way;
    logic [dcache_pkg::index_w-1:0]                          store_index;
    logic [dcache_pkg::word_sel_w-1:0]                       store_word;
    logic [dcache_pkg::word_w-1:0]                           store_data;
    logic                                                    plru_we;
    logic                                                    plru_way;
    logic [dcache_pkg::num_ways-1:0][dcache_pkg::tag_w-1:0] way_tag;
    logic [dcache_pkg::num_ways-1:0]                         way_valid;
    logic                                                    victim_way;
    logic [dcache_pkg::tag_w-1:0]                            victim_tag;
    logic                                                    victim_dirty;
    logic [dcache_pkg::word_w-1:0]                           hit_word;
    logic [dcache_pkg::line_w-1:0]                           victim_line;
    logic                                                    refill_we;
    logic [dcache_pkg::index_w-1:0]                          refill_index;
    logic [dcache_pkg::line_w-1:0]                           refill_line;
    logic                                                    refill_done;
    dcache_pkg::miss_state_t                                 miss_state;

    dcache_req_stage i_req (
        .clk, .reset, .req_valid, .req_write, .req_addr, .req_wdata, .req_wstrb,
        .way_tag, .way_valid, .hit_word, .refill_done, .miss_state,
        .busy, .rdata, .rd_en, .rd_index, .held_tag, .held_index, .lookup_miss,
        .hit_way, .word_sel, .store_we, .store_way, .store_index, .store_word,
        .store_data, .plru_we, .plru_way
    );

    dcache_tag_store i_tags (
        .clk, .reset, .rd_en, .rd_index,
        .refill_we, .refill_tag(held_tag), .refill_index,
        .store_we, .store_way, .store_index, .plru_we, .plru_way,
        .way_tag, .way_valid, .victim_way, .victim_tag, .victim_dirty
    );

    dcache_data_store i_data (
        .clk, .rd_en, .rd_index, .hit_way, .word_sel, .victim_way,
        .refill_we, .refill_index, .refill_line,
        .store_we, .store_way, .store_index, .store_word, .store_data,
        .hit_word, .victim_line
    );

    dcache_miss_fsm i_miss (
        .clk, .reset, .lookup_miss, .held_tag, .held_index,
        .victim_way, .victim_tag, .victim_dirty, .victim_line,
        .mem_rd_rdy, .mem_ret_valid, .mem_ret_data, .mem_wr_rdy, .mem_wr_done,
        .mem_rd_req, .mem_rd_addr, .mem_wr_req, .mem_wr_addr, .mem_wr_data,
        .refill_we, .refill_index, .refill_line, .refill_done, .miss_state
    );

endmodule

// File: tb.f
source/dcache_pkg.sv
source/dcache_req_stage.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_miss_fsm.sv
source/dcache_top.sv
test/dcache_sva.sv
test/dcache_tb.sv

// File: test/dcache_sva.sv
`timescale 1ns/1ps

module dcache_sva (
    input logic                              clk,
    input logic                              reset,
    input logic                              req_valid,
    input logic                              busy,
    input logic                              mem_rd_req,
    input logic [dcache_pkg::addr_w-1:0]     mem_rd_addr,
    input logic                              mem_rd_rdy,
    input logic                              mem_wr_req,
    input logic [dcache_pkg::addr_w-1:0]     mem_wr_addr,
    input logic [dcache_pkg::line_w-1:0]     mem_wr_data,
    input logic                              mem_wr_rdy
);
    int   fail_count = 0;
    logic seen_req;

    always_ff @(posedge clk) begin
        if (reset)
            seen_req <= 1'b0;
        else if (req_valid)
            seen_req <= 1'b1;
    end

    reset_clears: assert property (@(posedge clk)
        reset |=> !busy && !mem_rd_req && !mem_wr_req)
        else begin fail_count++; $error("busy or memory request set after reset"); end

    // idle until the CPU asks for something
    quiet_before_req: assert property (@(posedge clk) disable iff (reset)
        !seen_req |-> !busy && !mem_rd_req && !mem_wr_req)
        else begin fail_count++; $error("activity before the first request"); end

    rd_held: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req && !mem_rd_rdy |=> mem_rd_req && $stable(mem_rd_addr))
        else begin fail_count++; $error("read request dropped or changed before ready"); end

    wr_held: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req && !mem_wr_rdy |=> mem_wr_req && $stable(mem_wr_addr)
                                      && $stable(mem_wr_data))
        else begin fail_count++; $error("write request dropped or changed before ready"); end

    busy_on_mem: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req || mem_wr_req |-> busy)
        else begin fail_count++; $error("memory access while not busy"); end

endmodule

bind dcache_top dcache_sva i_sva (
    .clk, .reset, .req_valid, .busy, .mem_rd_req, .mem_rd_addr, .mem_rd_rdy,
    .mem_wr_req, .mem_wr_addr, .mem_wr_data, .mem_wr_rdy
);

// File: test/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    localparam int num_requests = 226;
    localparam int period_ns    = 100;

    logic                            clk = 1'b0;
    logic                            reset;
    logic                            req_valid;
    logic                            req_write;
    logic [dcache_pkg::addr_w-1:0]   req_addr;
    logic [dcache_pkg::word_w-1:0]   req_wdata;
    logic [dcache_pkg::strb_w-1:0]   req_wstrb;
    logic                            busy;
    logic [dcache_pkg::word_w-1:0]   rdata;
    logic                            mem_rd_req;
    logic [dcache_pkg::addr_w-1:0]   mem_rd_addr;
    logic                            mem_rd_rdy;
    logic                            mem_ret_valid;
    logic [dcache_pkg::line_w-1:0]   mem_ret_data;
    logic                            mem_wr_req;
    logic [dcache_pkg::addr_w-1:0]   mem_wr_addr;
    logic [dcache_pkg::line_w-1:0]   mem_wr_data;
    logic                            mem_wr_rdy;
    logic                            mem_wr_done;

    logic [dcache_pkg::line_w-1:0]   mem    [256];  // indexed by addr[11:4]
    logic [dcache_pkg::line_w-1:0]   shadow [256];  // what the CPU should see
    logic [31:0]                     rng = 32'habe3_6e3a;
    logic [31:0]                     last_rd_addr;
    int                              errors = 0;
    int                              checks = 0;
    int                              rd_count = 0;
    int                              wr_count = 0;
    int                              test_num = 1;
    int                              err_mark = 0;

    always #(period_ns / 2) clk = ~clk;

    dcache_top i_dut (.*);

    function automatic logic [31:0] rand32();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'h6b43_a9b5;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        return shadow[addr[11:4]][addr[3:2]*32 +: 32];
    endfunction

    function automatic int total_errors();
        return errors + i_dut.i_sva.fail_count;
    endfunction

    task automatic expect_equal(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %0d %s: %0d errors", test_num, name, total_errors() - err_mark);
        err_mark = total_errors();
        test_num++;
    endtask

    // one CPU request, from acceptance to completion
    task automatic access(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] strb, output logic [31:0] data, output int cycles);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        @(negedge clk);
        while (busy)
            @(negedge clk);
        @(posedge clk);
        #1 req_valid = 1'b0;
        cycles = 1;
        @(negedge clk);
        while (busy) begin
            cycles++;
            @(negedge clk);
        end
        data = rdata;  // stable before the completing edge
        @(posedge clk);
        #1;
    endtask

    task automatic do_load(input logic [31:0] addr, output int cycles);
        logic [31:0] data;
        access(1'b0, addr, 32'h0, 4'h0, data, cycles);
        expect_equal("rdata", data, shadow_word(addr));
    endtask

    task automatic do_store(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb);
        logic [31:0] ignored_data;
        int          cycles;
        access(1'b1, addr, wdata, strb, ignored_data, cycles);
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                shadow[addr[11:4]][addr[3:2]*32 + b*8 +: 8] = wdata[b*8 +: 8];
        end
    endtask

    task automatic serve_read();
        int unsigned wait_cycles;
        logic [7:0]  line_idx;
        wait_cycles = rand32() % 4;
        repeat (wait_cycles) @(posedge clk);
        @(posedge clk);
        #1 mem_rd_rdy = 1'b1;
        @(negedge clk);
        last_rd_addr = mem_rd_addr;
        line_idx     = mem_rd_addr[11:4];
        rd_count++;
        @(posedge clk);
        #1 mem_rd_rdy = 1'b0;
        mem_ret_valid = 1'b1;
        mem_ret_data  = mem[line_idx];
        @(posedge clk);
        #1 mem_ret_valid = 1'b0;
    endtask

    task automatic serve_write();
        int unsigned wait_cycles;
        logic [7:0]  line_idx;
        wait_cycles = rand32() % 4;
        repeat (wait_cycles) @(posedge clk);
        @(posedge clk);
        #1 mem_wr_rdy = 1'b1;
        @(negedge clk);
        line_idx = mem_wr_addr[11:4];
        wr_count++;
        expect_equal("mem_wr_data", mem_wr_data, shadow[line_idx]);
        mem[line_idx] = mem_wr_data;
        @(posedge clk);
        #1 mem_wr_rdy = 1'b0;
        mem_wr_done = 1'b1;
        @(posedge clk);
        #1 mem_wr_done = 1'b0;
    endtask

    // memory model
    initial begin
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data  = '0;
        mem_wr_rdy    = 1'b0;
        mem_wr_done   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            for (int w = 0; w < 4; w++)
                mem[i][w*32 +: 32] = fill_word(32'(i * 16 + w * 4));
            shadow[i] = mem[i];
        end
        forever begin
            @(negedge clk);
            if (mem_wr_req)
                serve_write();
            else if (mem_rd_req)
                serve_read();
        end
    end

    initial begin
        #(num_requests * 40 * period_ns);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] r;
        int          cycles;
        int          marker;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        reset     = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;

        repeat (3) @(posedge clk);
        #1;
        finish_test("idle after reset");

        addr   = 32'h0000_0518;  // tag 5, set 1, word 2
        marker = rd_count;
        do_load(addr, cycles);
        expect_equal("mem read count", rd_count - marker, 1);
        expect_equal("mem_rd_addr", last_rd_addr, {addr[31:4], 4'h0});
        do_load(addr, cycles);
        expect_equal("reload latency", cycles, 1);
        finish_test("cold load and reload");

        for (int i = 0; i < 8; i++) begin
            r = rand32();
            do_store({20'h0, 4'(1 + i % 2), 4'h3, 2'(i / 2), 2'b00}, rand32(), r[3:0]);
        end
        for (int i = 0; i < 8; i++)
            do_load({20'h0, 4'(1 + i % 2), 4'h3, 2'(i / 2), 2'b00}, cycles);
        finish_test("strobed stores");

        do_load(32'h0000_0194, cycles);  // set 9, way 0
        do_store(32'h0000_0298, rand32(), 4'hf);
        marker = wr_count;
        do_load(32'h0000_0390, cycles);  // evicts the clean line
        expect_equal("mem write count", wr_count, marker);
        do_load(32'h0000_019c, cycles);  // evicts the dirty line
        expect_equal("mem write count", wr_count, marker + 1);
        finish_test("eviction");

        for (int t = 1; t <= 4; t++)
            do_store({20'h0, 4'(t), 4'hc, 4'h4}, rand32(), 4'hf);
        finish_test("writebacks under back-pressure");

        for (int i = 0; i < 200; i++) begin
            r    = rand32();
            addr = {20'h0, 1'b0, r[6:4], 1'b0, r[9:8], 1'b0, r[11:10], 2'b00};
            if (r[0])
                do_store(addr, rand32(), r[15:12]);
            else
                do_load(addr, cycles);
        end
        finish_test("random mix");

        $display("%0d tests, %0d checks, %0d errors", test_num - 1, checks, total_errors());
        if (total_errors() == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
